/* include/mem_stage_defines.svh */
`ifndef MEM_STAGE_DEFINES_SVH
`define MEM_STAGE_DEFINES_SVH

// datapath widths
`define MEM_XLEN        32      // data and address width
`define MEM_LANES       2       // issue width
`define MEM_ALUOP_W     8
`define MEM_REG_ADDR_W  5       // general register index
`define MEM_CSR_ADDR_W  14
`define MEM_CAUSE_W     7       // one exception cause code
`define MEM_EXC_W       5       // exception flag vector

// load opcodes as decoded by the execute stage
`define ALU_LDB         8'h20   // byte, sign extended
`define ALU_LDBU        8'h21   // byte, zero extended
`define ALU_LDH         8'h22   // halfword, sign extended
`define ALU_LDHU        8'h23   // halfword, zero extended
`define ALU_LDW         8'h24
`define ALU_LLW         8'h25   // load-linked word

`endif

/* hw/mem_stage_pkg.sv */
`include "mem_stage_defines.svh"

package mem_stage_pkg;

    typedef enum logic [1:0] {
        LOAD_BYTE = 2'd0,
        LOAD_HALF = 2'd1,
        LOAD_WORD = 2'd2
    } load_size_e;

    // one cache word, read as bytes or as halfwords
    typedef union packed {
        logic [`MEM_XLEN/8-1:0][7:0]   bytes;
        logic [`MEM_XLEN/16-1:0][15:0] halves;
    } cache_word_u;

    typedef struct packed {
        logic       is_load;    // only set for a valid lane
        load_size_e size;
        logic       sign_ext;
    } load_ctrl_t;

    typedef struct packed {
        logic [`MEM_EXC_W-1:0]   flags;
        logic [`MEM_CAUSE_W-1:0] pc_cause;
        logic [`MEM_CAUSE_W-1:0] instbuffer_cause;
        logic [`MEM_CAUSE_W-1:0] decoder_cause;
        logic [`MEM_CAUSE_W-1:0] dispatch_cause;
        logic [`MEM_CAUSE_W-1:0] execute_cause;
    } exc_info_t;

    // one lane coming from execute
    typedef struct packed {
        logic [`MEM_XLEN-1:0]       pc;
        logic [`MEM_XLEN-1:0]       mem_addr;
        logic [`MEM_ALUOP_W-1:0]    aluop;
        logic                       reg_we;
        logic [`MEM_REG_ADDR_W-1:0] reg_addr;
        logic [`MEM_XLEN-1:0]       reg_data;   // execute result
        logic                       csr_we;
        logic [`MEM_CSR_ADDR_W-1:0] csr_addr;
        logic [`MEM_XLEN-1:0]       csr_data;
        logic                       valid;
        logic                       privilege;
        logic                       ertn;
        logic                       idle;
        logic                       llw_scw;
        exc_info_t                  exc;
    } mem_lane_t;

    // one registered lane towards writeback and commit
    typedef struct packed {
        logic                       valid;
        logic                       reg_we;
        logic [`MEM_REG_ADDR_W-1:0] reg_addr;
        logic [`MEM_XLEN-1:0]       reg_data;
        logic                       csr_we;
        logic [`MEM_CSR_ADDR_W-1:0] csr_addr;
        logic [`MEM_XLEN-1:0]       csr_data;
        logic                       llw_scw;
        logic [`MEM_XLEN-1:0]       pc;
        logic [`MEM_XLEN-1:0]       addr;
        logic                       privilege;
        logic                       ertn;
        logic                       idle;
        exc_info_t                  exc;
    } wb_lane_t;

endpackage

/* hw/mem_stall_ctrl.sv */
`timescale 1ns/1ps
`include "mem_stage_defines.svh"

module mem_stall_ctrl (
    input  mem_stage_pkg::mem_lane_t  [`MEM_LANES-1:0] lanes_i,
    input  logic                                       dcache_data_ok_i,
    output mem_stage_pkg::load_ctrl_t [`MEM_LANES-1:0] load_ctrl_o,
    output logic                                       advance_o,
    output logic                                       pause_mem_o
);
    import mem_stage_pkg::*;

    logic [`MEM_LANES-1:0] lane_wait;   // valid load still waiting on the cache
    logic [`MEM_LANES-1:0] lane_exc;

    always_comb begin
        for (int i = 0; i < `MEM_LANES; i++) begin
            load_ctrl_o[i] = '{is_load: 1'b0, size: LOAD_WORD, sign_ext: 1'b0};
            case (lanes_i[i].aluop)
                `ALU_LDB: begin
                    load_ctrl_o[i] = '{lanes_i[i].valid, LOAD_BYTE, 1'b1};
                end
                `ALU_LDBU: begin
                    load_ctrl_o[i] = '{lanes_i[i].valid, LOAD_BYTE, 1'b0};
                end
                `ALU_LDH: begin
                    load_ctrl_o[i] = '{lanes_i[i].valid, LOAD_HALF, 1'b1};
                end
                `ALU_LDHU: begin
                    load_ctrl_o[i] = '{lanes_i[i].valid, LOAD_HALF, 1'b0};
                end
                `ALU_LDW, `ALU_LLW: begin
                    load_ctrl_o[i] = '{lanes_i[i].valid, LOAD_WORD, 1'b0};
                end
                default: begin
                    load_ctrl_o[i] = '{is_load: 1'b0, size: LOAD_WORD, sign_ext: 1'b0};
                end
            endcase
        end
    end

    always_comb begin
        for (int i = 0; i < `MEM_LANES; i++) begin
            lane_wait[i] = load_ctrl_o[i].is_load & ~dcache_data_ok_i;
            lane_exc[i]  = |lanes_i[i].exc.flags;
        end
    end

    // an excepting lane flushes the pipe, so never hold it
    assign pause_mem_o = (|lane_wait) & ~(|lane_exc);
    assign advance_o   = ~pause_mem_o;

endmodule

/* hw/mem_load_align.sv */
`timescale 1ns/1ps
`include "mem_stage_defines.svh"

module mem_load_align (
    input  mem_stage_pkg::load_ctrl_t  load_ctrl_i,
    input  logic [1:0]                 addr_offset_i,
    input  logic [`MEM_XLEN-1:0]       exe_data_i,
    input  mem_stage_pkg::cache_word_u cache_word_i,
    output logic [`MEM_XLEN-1:0]       wb_data_o
);
    import mem_stage_pkg::*;

    logic [7:0]           sel_byte;
    logic [15:0]          sel_half;
    logic                 half_aligned;
    logic                 byte_sign;
    logic                 half_sign;
    logic [`MEM_XLEN-1:0] byte_ext;
    logic [`MEM_XLEN-1:0] half_ext;

    assign sel_byte     = cache_word_i.bytes[addr_offset_i];
    assign half_aligned = ~addr_offset_i[0];   // offsets 0 and 2 only
    assign sel_half     = half_aligned ? cache_word_i.halves[addr_offset_i[1]] : 16'h0000;

    assign byte_sign = load_ctrl_i.sign_ext & sel_byte[7];
    assign half_sign = load_ctrl_i.sign_ext & sel_half[15];

    assign byte_ext = {{(`MEM_XLEN-8){byte_sign}}, sel_byte};
    assign half_ext = {{(`MEM_XLEN-16){half_sign}}, sel_half};

    always_comb begin
        if (!load_ctrl_i.is_load) begin
            wb_data_o = exe_data_i;   // alu result goes straight through
        end else begin
            case (load_ctrl_i.size)
                LOAD_BYTE: begin
                    wb_data_o = byte_ext;
                end
                LOAD_HALF: begin
                    wb_data_o = half_ext;
                end
                default: begin
                    wb_data_o = cache_word_i;   // ld.w and ll.w
                end
            endcase
        end
    end

endmodule

/* hw/mem_wb_reg.sv */
`timescale 1ns/1ps
`include "mem_stage_defines.svh"

module mem_wb_reg (
    input  logic                                       clk,
    input  logic                                       reset_i,
    input  logic                                       advance_i,
    input  mem_stage_pkg::mem_lane_t [`MEM_LANES-1:0]  lanes_i,
    input  logic [`MEM_LANES-1:0][`MEM_XLEN-1:0]       wb_data_i,
    output mem_stage_pkg::wb_lane_t  [`MEM_LANES-1:0]  wb_lanes_o
);
    import mem_stage_pkg::*;

    wb_lane_t [`MEM_LANES-1:0] next_lanes;

    always_comb begin
        for (int i = 0; i < `MEM_LANES; i++) begin
            next_lanes[i].valid     = lanes_i[i].valid;
            next_lanes[i].reg_we    = lanes_i[i].reg_we;
            next_lanes[i].reg_addr  = lanes_i[i].reg_addr;
            next_lanes[i].reg_data  = wb_data_i[i];   // aligned load or alu result
            next_lanes[i].csr_we    = lanes_i[i].csr_we;
            next_lanes[i].csr_addr  = lanes_i[i].csr_addr;
            next_lanes[i].csr_data  = lanes_i[i].csr_data;
            next_lanes[i].llw_scw   = lanes_i[i].llw_scw;
            next_lanes[i].pc        = lanes_i[i].pc;
            next_lanes[i].addr      = lanes_i[i].mem_addr;
            next_lanes[i].privilege = lanes_i[i].privilege;
            next_lanes[i].ertn      = lanes_i[i].ertn;
            next_lanes[i].idle      = lanes_i[i].idle;
            next_lanes[i].exc       = lanes_i[i].exc;
            if (!advance_i) begin   // bubble while waiting on the cache
                next_lanes[i].valid   = 1'b0;
                next_lanes[i].reg_we  = 1'b0;
                next_lanes[i].csr_we  = 1'b0;
                next_lanes[i].llw_scw = 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int i = 0; i < `MEM_LANES; i++) begin
                wb_lanes_o[i].valid   <= 1'b0;
                wb_lanes_o[i].reg_we  <= 1'b0;
                wb_lanes_o[i].csr_we  <= 1'b0;
                wb_lanes_o[i].llw_scw <= 1'b0;
            end
        end else begin
            wb_lanes_o <= next_lanes;
        end
    end

endmodule

/* hw/mem_stage.sv */
`timescale 1ns/1ps
`include "mem_stage_defines.svh"

module mem_stage (
    input  logic                                       clk,
    input  logic                                       reset_i,
    input  mem_stage_pkg::mem_lane_t [`MEM_LANES-1:0]  lanes_i,
    input  mem_stage_pkg::cache_word_u                 dcache_rdata_i,
    input  logic                                       dcache_data_ok_i,   // level, word valid
    output mem_stage_pkg::wb_lane_t  [`MEM_LANES-1:0]  wb_lanes_o,
    output logic                                       pause_mem_o
);
    import mem_stage_pkg::*;

    load_ctrl_t [`MEM_LANES-1:0]          load_ctrl;
    logic [`MEM_LANES-1:0][`MEM_XLEN-1:0] wb_data;
    logic                                 advance;

    mem_stall_ctrl u_stall_ctrl (
        .lanes_i          (lanes_i),
        .dcache_data_ok_i (dcache_data_ok_i),
        .load_ctrl_o      (load_ctrl),
        .advance_o        (advance),
        .pause_mem_o      (pause_mem_o)
    );

    // one aligner per lane, both see the same cache word
    for (genvar g = 0; g < `MEM_LANES; g++) begin : g_align
        mem_load_align u_load_align (
            .load_ctrl_i   (load_ctrl[g]),
            .addr_offset_i (lanes_i[g].mem_addr[1:0]),
            .exe_data_i    (lanes_i[g].reg_data),
            .cache_word_i  (dcache_rdata_i),
            .wb_data_o     (wb_data[g])
        );
    end

    mem_wb_reg u_wb_reg (
        .clk        (clk),
        .reset_i    (reset_i),
        .advance_i  (advance),
        .lanes_i    (lanes_i),
        .wb_data_i  (wb_data),
        .wb_lanes_o (wb_lanes_o)
    );

endmodule

/* verification/mem_stage_assert.sv */
`timescale 1ns/1ps
`include "mem_stage_defines.svh"

module mem_stage_assert (
    input logic                                      clk,
    input logic                                      reset_i,
    input mem_stage_pkg::mem_lane_t [`MEM_LANES-1:0] lanes_i,
    input mem_stage_pkg::wb_lane_t  [`MEM_LANES-1:0] wb_lanes_i,
    input logic                                      pause_mem_i
);
    import mem_stage_pkg::*;

    int   fail_count = 0;   // summed by the testbench
    logic out_active;       // any valid or write enable
    logic out_valid;
    logic in_exc;           // any lane with an exception flag

    always_comb begin
        out_active = 1'b0;
        out_valid  = 1'b0;
        in_exc     = 1'b0;
        for (int i = 0; i < `MEM_LANES; i++) begin
            out_active = out_active | wb_lanes_i[i].valid | wb_lanes_i[i].reg_we
                         | wb_lanes_i[i].csr_we;
            out_valid  = out_valid | wb_lanes_i[i].valid;
            in_exc     = in_exc | (|lanes_i[i].exc.flags);
        end
    end

    a_reset_idle: assert property (@(posedge clk) reset_i |=> !out_active)
        else begin
            $error("valid or write enable high after a reset cycle");
            fail_count++;
        end

    a_no_pause_on_exc: assert property (@(posedge clk) disable iff (reset_i)
                                        in_exc |-> !pause_mem_i)
        else begin
            $error("pause raised while a lane has an exception");
            fail_count++;
        end

    // a stalled cycle must register a bubble
    a_bubble_after_pause: assert property (@(posedge clk) disable iff (reset_i)
                                           pause_mem_i |=> !out_valid)
        else begin
            $error("valid lane registered during a pause");
            fail_count++;
        end

endmodule

/* verification/mem_stage_tb.sv */
`timescale 1ns/1ps
`include "mem_stage_defines.svh"

module mem_stage_tb;
    import mem_stage_pkg::*;

    localparam int         HALF_PERIOD = 20;    // 40 ns clock
    localparam int         DRIVE_DELAY = 2;
    localparam int         RESET_CYCLES = 16;
    localparam logic [7:0] OP_ADD = 8'h01;      // any non-load op
    localparam logic [31:0] WORD_NEG = 32'hF2E3D4C5;   // every byte has bit 7 set
    localparam logic [31:0] WORD_POS = 32'h12345678;

    // one table row with index 0 and 1 selecting the lane
    typedef struct packed {
        logic [`MEM_LANES-1:0][`MEM_ALUOP_W-1:0] aluop;
        logic [`MEM_LANES-1:0]                   valid;
        logic [`MEM_LANES-1:0][1:0]              offset;
        logic [`MEM_LANES-1:0][`MEM_XLEN-1:0]    exe;
        logic [`MEM_LANES-1:0][`MEM_EXC_W-1:0]   exc;
        logic [`MEM_XLEN-1:0]                    cache;
        logic                                    data_ok;
        logic                                    exp_pause;
        logic [`MEM_LANES-1:0][`MEM_XLEN-1:0]    exp_data;
    } row_t;

    logic                         clk;
    logic                         reset_i;
    mem_lane_t [`MEM_LANES-1:0]   lanes;
    cache_word_u                  dcache_rdata;
    logic                         dcache_data_ok;
    wb_lane_t  [`MEM_LANES-1:0]   wb_lanes;
    logic                         pause_mem;

    row_t   rows[$];
    integer seed;
    int     errors;
    int     checks;
    int     cycles;
    int     cycle_limit;
    int     total_errors;

    mem_stage u_mem_stage (
        .clk              (clk),
        .reset_i          (reset_i),
        .lanes_i          (lanes),
        .dcache_rdata_i   (dcache_rdata),
        .dcache_data_ok_i (dcache_data_ok),
        .wb_lanes_o       (wb_lanes),
        .pause_mem_o      (pause_mem)
    );

    bind mem_stage mem_stage_assert u_mem_stage_assert (
        .clk        (clk),
        .reset_i    (reset_i),
        .lanes_i    (lanes_i),
        .wb_lanes_i (wb_lanes_o),
        .pause_mem_i (pause_mem_o)
    );

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    // from_exe bit set means that lane expects its own exe data back
    task automatic add_row(input logic [7:0] a0, input logic v0, input logic [1:0] o0,
                           input logic [4:0] x0, input logic [7:0] a1, input logic v1,
                           input logic [1:0] o1, input logic [4:0] x1,
                           input logic [31:0] cache, input logic ok, input logic pause,
                           input logic [1:0] from_exe, input logic [31:0] e0,
                           input logic [31:0] e1);
        row_t r;
        r           = '0;
        r.aluop     = {a1, a0};
        r.valid     = {v1, v0};
        r.offset    = {o1, o0};
        r.exc       = {x1, x0};
        r.exe[0]    = $random(seed);
        r.exe[1]    = $random(seed);
        r.cache     = cache;
        r.data_ok   = ok;
        r.exp_pause = pause;
        r.exp_data[0] = from_exe[0] ? r.exe[0] : e0;
        r.exp_data[1] = from_exe[1] ? r.exe[1] : e1;
        rows.push_back(r);
    endtask

    task automatic apply_row(input row_t r);
        logic [31:0] rnd;
        for (int i = 0; i < `MEM_LANES; i++) begin
            lanes[i]           = '0;
            rnd                = $random(seed);
            lanes[i].pc        = rnd;
            rnd                = $random(seed);
            lanes[i].mem_addr  = {rnd[31:2], r.offset[i]};
            lanes[i].aluop     = r.aluop[i];
            lanes[i].reg_we    = 1'b1;
            rnd                = $random(seed);
            lanes[i].reg_addr  = rnd[4:0];
            lanes[i].csr_we    = rnd[5];
            lanes[i].privilege = rnd[6];
            lanes[i].ertn      = rnd[7];
            lanes[i].idle      = rnd[8];
            lanes[i].exc.execute_cause = rnd[15:9];
            lanes[i].csr_addr  = rnd[29:16];
            lanes[i].reg_data  = r.exe[i];
            rnd                = $random(seed);
            lanes[i].csr_data  = rnd;
            rnd                = $random(seed);
            lanes[i].exc.pc_cause         = rnd[6:0];
            lanes[i].exc.instbuffer_cause = rnd[13:7];
            lanes[i].exc.decoder_cause    = rnd[20:14];
            lanes[i].exc.dispatch_cause   = rnd[27:21];
            lanes[i].valid     = r.valid[i];
            lanes[i].llw_scw   = (r.aluop[i] == `ALU_LLW);
            lanes[i].exc.flags = r.exc[i];
        end
        dcache_rdata   = r.cache;
        dcache_data_ok = r.data_ok;
    endtask

    task automatic check_idle();
        for (int i = 0; i < `MEM_LANES; i++) begin
            check_value($sformatf("wb_lanes_o[%0d].valid", i), 32'(wb_lanes[i].valid), 0);
            check_value($sformatf("wb_lanes_o[%0d].reg_we", i), 32'(wb_lanes[i].reg_we), 0);
            check_value($sformatf("wb_lanes_o[%0d].csr_we", i), 32'(wb_lanes[i].csr_we), 0);
        end
    endtask

    // lanes still hold the row that was registered at the last edge
    task automatic check_outputs(input row_t r);
        string p;
        for (int i = 0; i < `MEM_LANES; i++) begin
            p = $sformatf("wb_lanes_o[%0d]", i);
            if (r.exp_pause) begin   // stalled row must leave a bubble
                check_value({p, ".valid"}, 32'(wb_lanes[i].valid), 0);
                check_value({p, ".reg_we"}, 32'(wb_lanes[i].reg_we), 0);
                check_value({p, ".csr_we"}, 32'(wb_lanes[i].csr_we), 0);
                check_value({p, ".llw_scw"}, 32'(wb_lanes[i].llw_scw), 0);
            end else begin
                check_value({p, ".valid"}, 32'(wb_lanes[i].valid), 32'(lanes[i].valid));
                check_value({p, ".reg_we"}, 32'(wb_lanes[i].reg_we), 32'(lanes[i].reg_we));
                check_value({p, ".reg_addr"}, 32'(wb_lanes[i].reg_addr),
                            32'(lanes[i].reg_addr));
                check_value({p, ".reg_data"}, wb_lanes[i].reg_data, r.exp_data[i]);
                check_value({p, ".csr_we"}, 32'(wb_lanes[i].csr_we), 32'(lanes[i].csr_we));
                check_value({p, ".csr_addr"}, 32'(wb_lanes[i].csr_addr),
                            32'(lanes[i].csr_addr));
                check_value({p, ".csr_data"}, wb_lanes[i].csr_data, lanes[i].csr_data);
                check_value({p, ".llw_scw"}, 32'(wb_lanes[i].llw_scw), 32'(lanes[i].llw_scw));
                check_value({p, ".pc"}, wb_lanes[i].pc, lanes[i].pc);
                check_value({p, ".addr"}, wb_lanes[i].addr, lanes[i].mem_addr);
                check_value({p, ".privilege"}, 32'(wb_lanes[i].privilege),
                            32'(lanes[i].privilege));
                check_value({p, ".ertn"}, 32'(wb_lanes[i].ertn), 32'(lanes[i].ertn));
                check_value({p, ".idle"}, 32'(wb_lanes[i].idle), 32'(lanes[i].idle));
                check_value({p, ".exc[31:0]"}, wb_lanes[i].exc[31:0], lanes[i].exc[31:0]);
                check_value({p, ".exc[39:32]"}, 32'(wb_lanes[i].exc[39:32]),
                            32'(lanes[i].exc[39:32]));
            end
        end
    endtask

    task automatic build_table();
        // byte loads at every offset
        add_row(`ALU_LDB, 1, 2'd0, 5'h0, `ALU_LDBU, 1, 2'd1, 5'h0, WORD_NEG, 1, 0, 2'b00,
                32'hFFFFFFC5, 32'h000000D4);
        add_row(`ALU_LDBU, 1, 2'd2, 5'h0, `ALU_LDB, 1, 2'd3, 5'h0, WORD_NEG, 1, 0, 2'b00,
                32'h000000E3, 32'hFFFFFFF2);
        add_row(`ALU_LDB, 1, 2'd1, 5'h0, `ALU_LDBU, 1, 2'd3, 5'h0, WORD_NEG, 1, 0, 2'b00,
                32'hFFFFFFD4, 32'h000000F2);
        add_row(`ALU_LDB, 1, 2'd2, 5'h0, `ALU_LDBU, 1, 2'd0, 5'h0, WORD_NEG, 1, 0, 2'b00,
                32'hFFFFFFE3, 32'h000000C5);
        // halfword loads where misaligned offsets give zero
        add_row(`ALU_LDH, 1, 2'd0, 5'h0, `ALU_LDHU, 1, 2'd2, 5'h0, WORD_NEG, 1, 0, 2'b00,
                32'hFFFFD4C5, 32'h0000F2E3);
        add_row(`ALU_LDHU, 1, 2'd0, 5'h0, `ALU_LDH, 1, 2'd2, 5'h0, WORD_NEG, 1, 0, 2'b00,
                32'h0000D4C5, 32'hFFFFF2E3);
        add_row(`ALU_LDH, 1, 2'd1, 5'h0, `ALU_LDHU, 1, 2'd3, 5'h0, WORD_NEG, 1, 0, 2'b00,
                32'h0, 32'h0);
        // word loads and plain alu lanes
        add_row(`ALU_LDW, 1, 2'd0, 5'h0, `ALU_LLW, 1, 2'd0, 5'h0, WORD_POS, 1, 0, 2'b00,
                WORD_POS, WORD_POS);
        add_row(OP_ADD, 1, 2'd1, 5'h0, `ALU_LDH, 1, 2'd2, 5'h0, WORD_POS, 1, 0, 2'b01,
                32'h0, 32'h00001234);
        add_row(OP_ADD, 1, 2'd0, 5'h0, OP_ADD, 1, 2'd3, 5'h0, WORD_POS, 1, 0, 2'b11,
                32'h0, 32'h0);
        // wait on the cache and then the same row with data
        add_row(`ALU_LDW, 1, 2'd0, 5'h0, OP_ADD, 1, 2'd0, 5'h0, WORD_POS, 0, 1, 2'b10,
                32'h0, 32'h0);
        add_row(`ALU_LDW, 1, 2'd0, 5'h0, OP_ADD, 1, 2'd0, 5'h0, WORD_POS, 1, 0, 2'b10,
                WORD_POS, 32'h0);
        add_row(OP_ADD, 1, 2'd0, 5'h0, `ALU_LDB, 1, 2'd0, 5'h0, WORD_NEG, 0, 1, 2'b01,
                32'h0, 32'h0);
        add_row(OP_ADD, 1, 2'd0, 5'h0, `ALU_LDB, 1, 2'd0, 5'h0, WORD_NEG, 1, 0, 2'b01,
                32'h0, 32'hFFFFFFC5);
        // exceptions mask the pause
        add_row(`ALU_LDB, 1, 2'd0, 5'h0, OP_ADD, 1, 2'd0, 5'h04, WORD_NEG, 0, 0, 2'b10,
                32'hFFFFFFC5, 32'h0);
        add_row(OP_ADD, 1, 2'd0, 5'h0, `ALU_LDW, 1, 2'd0, 5'h01, WORD_POS, 0, 0, 2'b01,
                32'h0, WORD_POS);
        add_row(OP_ADD, 1, 2'd0, 5'h10, `ALU_LDHU, 1, 2'd2, 5'h0, WORD_NEG, 0, 0, 2'b01,
                32'h0, 32'h0000F2E3);
        // invalid lane with a load opcode
        add_row(`ALU_LDB, 0, 2'd0, 5'h0, OP_ADD, 1, 2'd0, 5'h0, WORD_NEG, 0, 0, 2'b11,
                32'h0, 32'h0);
        add_row(`ALU_LDHU, 1, 2'd0, 5'h0, `ALU_LDHU, 1, 2'd2, 5'h0, WORD_NEG, 0, 1, 2'b00,
                32'h0, 32'h0);
    endtask

    initial begin
        seed           = 32'hb075;
        errors         = 0;
        checks         = 0;
        cycle_limit    = 0;
        reset_i        = 1'b1;
        lanes          = '0;
        dcache_rdata   = '0;
        dcache_data_ok = 1'b0;
        build_table();
        cycle_limit = rows.size() * 4 + 100;
        for (int i = 0; i < `MEM_LANES; i++) begin   // busy lanes while in reset
            lanes[i].valid  = 1'b1;
            lanes[i].reg_we = 1'b1;
            lanes[i].csr_we = 1'b1;
        end
        repeat (RESET_CYCLES) begin
            @(posedge clk);
            #1 check_idle();
        end
        #1;
        lanes   = '0;
        reset_i = 1'b0;
        @(posedge clk);
        #1 check_idle();
        #1;
        foreach (rows[i]) begin
            apply_row(rows[i]);
            @(negedge clk);
            check_value("pause_mem_o", 32'(pause_mem), 32'(rows[i].exp_pause));
            @(posedge clk);
            #1 check_outputs(rows[i]);
            #(DRIVE_DELAY - 1);
        end
        total_errors = errors + u_mem_stage.u_mem_stage_assert.fail_count;
        $display("checks: %0d  errors: %0d  assertion errors: %0d", checks, errors,
                 u_mem_stage.u_mem_stage_assert.fail_count);
        if (total_errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

    // watchdog on the clock count
    initial begin
        cycles = 0;
        wait (cycle_limit != 0);
        while (cycles < cycle_limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout: the run did not finish within %0d clock cycles", cycle_limit);
        $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

/* mem_stage.f */
+incdir+include
hw/mem_stage_pkg.sv
hw/mem_stall_ctrl.sv
hw/mem_load_align.sv
hw/mem_wb_reg.sv
hw/mem_stage.sv
verification/mem_stage_assert.sv
verification/mem_stage_tb.sv

/* Bender.yml */
package:
  name: mem_stage

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - hw/mem_stage_pkg.sv
      - hw/mem_stall_ctrl.sv
      - hw/mem_load_align.sv
      - hw/mem_wb_reg.sv
      - hw/mem_stage.sv
  - target: test
    include_dirs:
      - include
    files:
      - verification/mem_stage_assert.sv
      - verification/mem_stage_tb.sv
